/* design/adder_cfg_pkg.sv */
`default_nettype none

package adder_cfg_pkg;

    // operand widths
    localparam int total_width = 64;
    localparam int half_width  = total_width / 2;

    // prefix levels between pipeline registers
    localparam int levels_per_stage = 2;

    // encode register, then one register per group of levels
    // a final partial group still costs a full register
    function automatic int pipe_latency(int width, int lps = levels_per_stage);
        return 1 + ($clog2(width) + lps - 1) / lps;
    endfunction

endpackage

`default_nettype wire

/* design/carry_pkg.sv */
`default_nettype none

package carry_pkg;

    // per-span carry class, upper bit says carry may leave the span
    typedef enum logic [1:0] {
        carry_kill      = 2'b00,
        carry_propagate = 2'b10,
        carry_generate  = 2'b11
    } carry_status_t;

    // a propagating upper span takes the class of the span below it
    function automatic carry_status_t combine_status(carry_status_t upper,
                                                     carry_status_t lower);
        if (upper == carry_propagate)
            return lower;
        else
            return upper;
    endfunction

endpackage

`default_nettype wire

/* design/status_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module status_encoder #(
    parameter int width = adder_cfg_pkg::half_width
) (
    input  logic [width-1:0]                     a,
    input  logic [width-1:0]                     b,
    input  logic                                 cin,
    output carry_pkg::carry_status_t [width-1:0] status
);
    import carry_pkg::*;

    logic carry_zero;

    // carry out of bit zero is already known, so bit zero never propagates
    assign carry_zero = (a[0] & b[0]) | (a[0] & cin) | (b[0] & cin);

    always_comb
    begin
        status[0] = carry_zero ? carry_generate : carry_kill;
        for (int i = 1; i < width; i++)
        begin
            if (a[i] & b[i])
                status[i] = carry_generate;
            else if (a[i] | b[i])
                status[i] = carry_propagate;
            else
                status[i] = carry_kill;
        end
    end

endmodule

`default_nettype wire

/* design/prefix_level.sv */
`timescale 1ns/1ps
`default_nettype none

module prefix_level #(
    parameter int width = adder_cfg_pkg::half_width,
    parameter int span  = 1
) (
    input  carry_pkg::carry_status_t [width-1:0] status_in,
    output carry_pkg::carry_status_t [width-1:0] status_out
);
    import carry_pkg::*;

    // bits below span already cover everything down to bit zero
    always_comb
    begin
        status_out = status_in;
        for (int i = span; i < width; i++)
            status_out[i] = combine_status(status_in[i], status_in[i - span]);
    end

endmodule

`default_nettype wire

/* design/prefix_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module prefix_tree #(
    parameter int width            = adder_cfg_pkg::half_width,
    parameter int levels_per_stage = adder_cfg_pkg::levels_per_stage
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  carry_pkg::carry_status_t [width-1:0] status,
    output logic [width-1:0]                     carry
);
    import carry_pkg::*;

    localparam int levels = $clog2(width);

    carry_status_t [width-1:0] status_q;

    // encode register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < width; i++)
                status_q[i] <= carry_kill;
        end
        else
            status_q <= status;
    end

    for (genvar l = 0; l < levels; l++)
    begin : g_level
        carry_status_t [width-1:0] level_in;
        carry_status_t [width-1:0] level_out;
        carry_status_t [width-1:0] stage_out;

        if (l == 0)
        begin : g_first
            assign level_in = status_q;
        end
        else
        begin : g_next
            assign level_in = g_level[l - 1].stage_out;
        end

        prefix_level #(
            .width (width),
            .span  (1 << l)
        ) u_level (
            .status_in  (level_in),
            .status_out (level_out)
        );

        // register after each full group and after the last level
        if ((l + 1) % levels_per_stage == 0 || l == levels - 1)
        begin : g_reg
            always_ff @(posedge clk)
            begin
                if (reset)
                begin
                    for (int i = 0; i < width; i++)
                        stage_out[i] <= carry_kill;
                end
                else
                    stage_out <= level_out;
            end
        end
        else
        begin : g_wire
            assign stage_out = level_out;
        end
    end

    // fully resolved here, every bit is kill or generate
    always_comb
    begin
        for (int i = 0; i < width; i++)
            carry[i] = (g_level[levels - 1].stage_out[i] == carry_generate);
    end

endmodule

`default_nettype wire

/* design/operand_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_delay #(
    parameter int width = adder_cfg_pkg::half_width,
    parameter int depth = adder_cfg_pkg::pipe_latency(adder_cfg_pkg::half_width)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic             d_valid,
    output logic [width-1:0] d_a,
    output logic [width-1:0] d_b,
    output logic             d_cin
);
    logic             valid_q [depth];
    logic [width-1:0] a_q     [depth];
    logic [width-1:0] b_q     [depth];
    logic             cin_q   [depth];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
                valid_q[i] <= 1'b0;
        end
        else
        begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < depth; i++)
                valid_q[i] <= valid_q[i - 1];
        end
    end

    always_ff @(posedge clk)
    begin
        a_q[0]   <= a;
        b_q[0]   <= b;
        cin_q[0] <= cin;
        for (int i = 1; i < depth; i++)
        begin
            a_q[i]   <= a_q[i - 1];
            b_q[i]   <= b_q[i - 1];
            cin_q[i] <= cin_q[i - 1];
        end
    end

    assign d_valid = valid_q[depth - 1];
    assign d_a     = a_q[depth - 1];
    assign d_b     = b_q[depth - 1];
    assign d_cin   = cin_q[depth - 1];

endmodule

`default_nettype wire

/* design/prefix_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module prefix_adder #(
    parameter int width            = adder_cfg_pkg::half_width,
    parameter int levels_per_stage = adder_cfg_pkg::levels_per_stage
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             cin,
    output logic             out_valid,
    output logic [width-1:0] sum,
    output logic             cout
);
    import adder_cfg_pkg::*;
    import carry_pkg::*;

    localparam int latency = pipe_latency(width, levels_per_stage);

    carry_status_t [width-1:0] status;
    logic [width-1:0]          carry;
    logic [width-1:0]          d_a;
    logic [width-1:0]          d_b;
    logic                      d_cin;

    status_encoder #(
        .width (width)
    ) u_encoder (
        .a      (a),
        .b      (b),
        .cin    (cin),
        .status (status)
    );

    prefix_tree #(
        .width            (width),
        .levels_per_stage (levels_per_stage)
    ) u_tree (
        .clk    (clk),
        .reset  (reset),
        .status (status),
        .carry  (carry)
    );

    // operands wait in step with the tree
    operand_delay #(
        .width (width),
        .depth (latency)
    ) u_delay (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .cin      (cin),
        .d_valid  (out_valid),
        .d_a      (d_a),
        .d_b      (d_b),
        .d_cin    (d_cin)
    );

    // carry into bit i is the resolved carry out of bit i-1
    assign sum  = d_a ^ d_b ^ {carry[width-2:0], d_cin};
    assign cout = carry[width-1];

endmodule

`default_nettype wire

/* design/carry_select_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module carry_select_adder #(
    parameter int total_width      = adder_cfg_pkg::total_width,
    parameter int levels_per_stage = adder_cfg_pkg::levels_per_stage
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [total_width-1:0] a,
    input  logic [total_width-1:0] b,
    input  logic                   cin,
    output logic                   out_valid,
    output logic [total_width-1:0] sum,
    output logic                   cout
);
    localparam int half = total_width / 2;

    logic [half-1:0] sum_lo;
    logic            cout_lo;
    logic [half-1:0] sum_hi0;
    logic            cout_hi0;
    logic [half-1:0] sum_hi1;
    logic            cout_hi1;

    prefix_adder #(
        .width            (half),
        .levels_per_stage (levels_per_stage)
    ) u_lower (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a[half-1:0]),
        .b         (b[half-1:0]),
        .cin       (cin),
        .out_valid (out_valid),
        .sum       (sum_lo),
        .cout      (cout_lo)
    );

    // upper half computed for both possible carries
    prefix_adder #(
        .width            (half),
        .levels_per_stage (levels_per_stage)
    ) u_upper_c0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a[total_width-1:half]),
        .b         (b[total_width-1:half]),
        .cin       (1'b0),
        .out_valid (),
        .sum       (sum_hi0),
        .cout      (cout_hi0)
    );

    prefix_adder #(
        .width            (half),
        .levels_per_stage (levels_per_stage)
    ) u_upper_c1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a[total_width-1:half]),
        .b         (b[total_width-1:half]),
        .cin       (1'b1),
        .out_valid (),
        .sum       (sum_hi1),
        .cout      (cout_hi1)
    );

    // all three copies share one latency, so the select lines up
    assign sum  = {cout_lo ? sum_hi1 : sum_hi0, sum_lo};
    assign cout = cout_lo ? cout_hi1 : cout_hi0;

endmodule

`default_nettype wire

/* sim/tb_carry_select_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_carry_select_adder;
    import adder_cfg_pkg::*;

    // edges from an accepted operation to its result
    localparam int latency = 4;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic [total_width-1:0] a;
    logic [total_width-1:0] b;
    logic                   cin;
    logic                   out_valid;
    logic [total_width-1:0] sum;
    logic                   cout;

    logic [63:0] exp_sum    [$];
    logic        exp_cout   [$];
    logic        valid_hist [$];
    logic [63:0] vec_a      [$];
    logic [63:0] vec_b      [$];
    logic        vec_cin    [$];
    logic [63:0] vec_sum    [$];
    logic        vec_cout   [$];
    int          ops_issued;
    int          results_seen;
    int          reset_edges;

    carry_select_adder #(
        .total_width      (total_width),
        .levels_per_stage (levels_per_stage)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .cin       (cin),
        .out_valid (out_valid),
        .sum       (sum),
        .cout      (cout)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue_op(input logic [63:0] op_a, input logic [63:0] op_b,
                            input logic op_cin, input logic [63:0] op_sum,
                            input logic op_cout);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= op_a;
        b        <= op_b;
        cin      <= op_cin;
        exp_sum.push_back(op_sum);
        exp_cout.push_back(op_cout);
        ops_issued++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic issue_random();
        logic [63:0] ra;
        logic [63:0] rb;
        logic        rc;
        logic [64:0] full;
        ra = {$urandom(), $urandom()};
        rb = {$urandom(), $urandom()};
        // now and then a full propagate run
        if ($urandom_range(3, 0) == 0)
            rb = ~ra;
        rc   = 1'($urandom_range(1, 0));
        full = {1'b0, ra} + {1'b0, rb} + {64'd0, rc};
        issue_op(ra, rb, rc, full[63:0], full[64]);
    endtask

    task automatic wait_drain(input string phase);
        int n;
        idle_cycle();
        for (n = 0; n < 64; n++)
        begin
            if (exp_sum.size() == 0)
                break;
            @(posedge clk);
        end
        if (exp_sum.size() != 0)
            abort_run({"timeout waiting for results in ", phase});
    endtask

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [63:0] va;
        logic [63:0] vb;
        logic [63:0] vs;
        logic        vc;
        logic        vco;
        fd = $fopen("sim/adder_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open sim/adder_vectors.txt");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == 8'h23)
                    continue;
                cnt = $sscanf(line, "%h %h %h %h %h", va, vb, vc, vs, vco);
                if (cnt == 5)
                begin
                    vec_a.push_back(va);
                    vec_b.push_back(vb);
                    vec_cin.push_back(vc);
                    vec_sum.push_back(vs);
                    vec_cout.push_back(vco);
                end
                else if (cnt > 0)
                    abort_run({"malformed line in vector file: ", line});
            end
            $fclose(fd);
            if (vec_a.size() == 0)
                abort_run("vector file holds no operations");
        end
    endtask

    // out_valid must trail in_valid by exactly the latency
    always @(posedge clk)
    begin
        logic expect_valid;
        if (reset)
        begin
            reset_edges++;
            valid_hist.delete();
            if (reset_edges > 1)
                check_value("out_valid", 64'(out_valid), 64'd0);
        end
        else
        begin
            if (valid_hist.size() == latency)
                expect_valid = valid_hist.pop_front();
            else
                expect_valid = 1'b0;
            valid_hist.push_back(in_valid);
            check_value("out_valid", 64'(out_valid), 64'(expect_valid));
            if (out_valid)
            begin
                if (exp_sum.size() == 0)
                    abort_run("out_valid high with no operation outstanding");
                else
                begin
                    check_value("sum", sum, exp_sum.pop_front());
                    check_value("cout", 64'(cout), 64'(exp_cout.pop_front()));
                    results_seen++;
                end
            end
        end
    end

    initial
    begin
        int waited;
        int gap;
        void'($urandom(6));
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        cin      = 1'b0;
        load_vectors();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (6) idle_cycle();

        // lone operation after an idle stretch
        issue_op(64'h0000_0000_ffff_ffff, 64'h1, 1'b0, 64'h0000_0001_0000_0000, 1'b0);
        idle_cycle();
        for (waited = 1; waited <= 16; waited++)
        begin
            @(posedge clk);
            if (out_valid)
                break;
        end
        if (waited > 16)
            abort_run("no result for the single operation");
        check_value("latency", 64'(waited), 64'(latency));
        wait_drain("latency check");

        foreach (vec_a[i])
            issue_op(vec_a[i], vec_b[i], vec_cin[i], vec_sum[i], vec_cout[i]);
        wait_drain("vector replay");

        repeat (40)
        begin
            issue_random();
            gap = $urandom_range(3, 0);
            repeat (gap) idle_cycle();
        end
        wait_drain("gapped traffic");

        repeat (200) issue_random();
        wait_drain("random streaming");

        if (results_seen != ops_issued)
            abort_run("number of results differs from number of operations");
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
design/adder_cfg_pkg.sv
design/carry_pkg.sv
design/status_encoder.sv
design/prefix_level.sv
design/prefix_tree.sv
design/operand_delay.sv
design/prefix_adder.sv
design/carry_select_adder.sv
sim/tb_carry_select_adder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the carry-select adder testbench with Verilator.
# Run from any directory; all paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f files.f --top-module tb_carry_select_adder \
    --Mdir "$build_dir" -o sim_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/sim_top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "test failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

/* sim/adder_vectors.txt */
# a                b                cin sum              cout
# all fields hex, one operation per line
0000000000000000 0000000000000000 0 0000000000000000 0
0000000000000000 0000000000000000 1 0000000000000001 0
ffffffffffffffff 0000000000000001 0 0000000000000000 1
ffffffffffffffff 0000000000000000 1 0000000000000000 1
ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 1
ffffffffffffffff ffffffffffffffff 1 ffffffffffffffff 1
00000000ffffffff 0000000000000001 0 0000000100000000 0
00000000ffffffff 0000000000000000 1 0000000100000000 0
7fffffffffffffff 0000000000000001 0 8000000000000000 0
5555555555555555 aaaaaaaaaaaaaaaa 0 ffffffffffffffff 0
5555555555555555 aaaaaaaaaaaaaaaa 1 0000000000000000 1
0123456789abcdef fedcba9876543210 0 ffffffffffffffff 0
0123456789abcdef fedcba9876543210 1 0000000000000000 1
123456789abcdef0 1111111111111111 0 23456789abcdf001 0
8000000000000000 8000000000000000 0 0000000000000000 1
0000000080000000 0000000080000000 1 0000000100000001 0
fffffffeffffffff 0000000000000001 0 ffffffff00000000 0
deadbeefcafebabe 2152411035014541 1 0000000000000000 1
0000000100000000 ffffffff00000000 0 0000000000000000 1
0000000f0000000f 000000f0000000f0 1 000000ff00000100 0
